/* design/act_gbf_pkg.sv */
// activation buffer package: word and item widths, buffer sizes, payload types, FSM states
package act_gbf_pkg;

    // ========================================================================
    // buffer geometry
    // ========================================================================
    localparam int port_w = 32;
    localparam int addr_w = 6;
    localparam int region_words = 32;

    // ========================================================================
    // activation and flag items
    // ========================================================================
    localparam int act_w = 8;
    localparam int block_depth = 4;
    localparam int acts_per_word = port_w / act_w;
    localparam int flags_per_word = port_w / block_depth;

    // one buffer word and its addresses
    typedef logic [port_w-1:0] port_word_t;
    typedef logic [addr_w-1:0] gbf_addr_t;
    typedef logic [addr_w-2:0] region_ptr_t;

    // fill level, one extra bit so a full region reads 32
    typedef logic [addr_w-1:0] fill_t;

    typedef logic [act_w-1:0] act_t;
    typedef logic [block_depth-1:0] flag_t;

    // lane 0 sits in the low byte
    typedef logic [act_w*block_depth-1:0] act_block_t;

    typedef enum logic [1:0] {
        EMPTY,
        WAIT_DATA,
        HOLD
    } fetch_state_e;

    typedef enum logic [1:0] {
        GET_FLAG,
        GATHER,
        REQ,
        RELEASE
    } disp_state_e;

endpackage

/* design/gbf_sram.sv */
// global buffer memory, single port, 64 words with a registered read port
`timescale 1ns/100ps

module gbf_sram (
    input  logic                    clk,
    input  logic                    en,
    input  logic                    we,
    input  act_gbf_pkg::gbf_addr_t  addr,
    input  act_gbf_pkg::port_word_t wdata,
    output act_gbf_pkg::port_word_t rdata
);

    // low half holds activations, high half holds sparsity flags
    act_gbf_pkg::port_word_t mem [0:2**act_gbf_pkg::addr_w-1];

    // write takes the port, read data lands one cycle later
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    // rdata keeps its last value between reads

endmodule

/* design/gbf_arbiter.sv */
// buffer arbiter: per-region fill tracking, read pointers and write-first grant logic
`timescale 1ns/100ps

module gbf_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    patch_reset,
    input  logic                    wr_en,
    input  act_gbf_pkg::gbf_addr_t  wr_addr,
    input  act_gbf_pkg::port_word_t wr_data,
    input  logic                    act_rd_req,
    input  logic                    flag_rd_req,
    output logic                    act_rd_grant,
    output logic                    flag_rd_grant,
    output logic                    mem_en,
    output logic                    mem_we,
    output act_gbf_pkg::gbf_addr_t  mem_addr,
    output act_gbf_pkg::port_word_t mem_wdata
);

    act_gbf_pkg::fill_t       act_fill;
    act_gbf_pkg::fill_t       flag_fill;
    act_gbf_pkg::region_ptr_t act_ptr;
    act_gbf_pkg::region_ptr_t flag_ptr;
    logic                     wr_flag_region;
    logic                     act_ok;
    logic                     flag_ok;
    logic                     prio_flag;

    // ========================================================================
    // grant logic
    // ========================================================================

    // msb of the address picks the region
    assign wr_flag_region = wr_addr[act_gbf_pkg::addr_w-1];

    // a write owns the port, so reads wait for a free cycle
    assign act_ok  = act_rd_req && (act_fill != '0) && !wr_en && !patch_reset;
    assign flag_ok = flag_rd_req && (flag_fill != '0) && !wr_en && !patch_reset;

    // on contention the loser of the last tie goes first
    assign act_rd_grant  = act_ok && (!flag_ok || !prio_flag);
    assign flag_rd_grant = flag_ok && (!act_ok || prio_flag);

    assign mem_en    = wr_en || act_rd_grant || flag_rd_grant;
    assign mem_we    = wr_en;
    assign mem_wdata = wr_data;

    always_comb begin
        if (wr_en) begin
            mem_addr = wr_addr;
        end else if (flag_rd_grant) begin
            mem_addr = {1'b1, flag_ptr};
        end else begin
            mem_addr = {1'b0, act_ptr};
        end
    end

    // ========================================================================
    // fill levels and read pointers
    // ========================================================================

    // writes and grants never share a cycle, so one update per cycle at most
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_fill  <= '0;
            flag_fill <= '0;
            act_ptr   <= '0;
            flag_ptr  <= '0;
            prio_flag <= 1'b0;
        end else if (patch_reset) begin
            act_fill  <= '0;
            flag_fill <= '0;
            act_ptr   <= '0;
            flag_ptr  <= '0;
            prio_flag <= 1'b0;
        end else begin
            if (wr_en && !wr_flag_region) begin
                act_fill <= act_fill + 1'b1;
            end else if (act_rd_grant) begin
                act_fill <= act_fill - 1'b1;
                act_ptr  <= act_ptr + 1'b1;
            end
            if (wr_en && wr_flag_region) begin
                flag_fill <= flag_fill + 1'b1;
            end else if (flag_rd_grant) begin
                flag_fill <= flag_fill - 1'b1;
                flag_ptr  <= flag_ptr + 1'b1;
            end
            // tie seen: hand priority to whoever lost it
            if (act_ok && flag_ok) begin
                prio_flag <= act_rd_grant;
            end
        end
    end

    // ========================================================================
    // checks
    // ========================================================================

    // writer must not run past the reader in either region
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en && !patch_reset |->
            (wr_flag_region ? flag_fill : act_fill) != act_gbf_pkg::region_words)
        else $error("write into a full buffer region");

    assert property (@(posedge clk) disable iff (!rst_n)
        !(act_rd_grant && flag_rd_grant))
        else $error("both fetchers granted in one cycle");

    // a granted read must reach the memory as a read, not a write
    assert property (@(posedge clk) disable iff (!rst_n)
        (act_rd_grant || flag_rd_grant) |-> mem_en && !mem_we && !wr_en)
        else $error("read grant during a write cycle");

endmodule

/* design/stream_fetch.sv */
// stream fetcher: requests buffer words for one region and unpacks them left-first
`timescale 1ns/100ps

module stream_fetch #(
    parameter int item_w = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    patch_reset,
    input  logic                    rd_grant,
    input  act_gbf_pkg::port_word_t rdata,
    input  logic                    item_take,
    output logic                    rd_req,
    output logic                    item_valid,
    output logic [item_w-1:0]       item
);

    act_gbf_pkg::fetch_state_e state;
    act_gbf_pkg::fetch_state_e state_nxt;
    act_gbf_pkg::port_word_t   word_q;
    act_gbf_pkg::port_word_t   live_q;
    logic                      take;
    logic                      last_take;

    // ========================================================================
    // item output
    // ========================================================================
    assign item_valid = (state == act_gbf_pkg::HOLD);
    assign item       = word_q[act_gbf_pkg::port_w-1 -: item_w];
    assign take       = item_valid && item_take;

    // live_q marks the unread slots, shifting left with the data
    assign last_take = take && ((live_q << item_w) == '0);

    always_comb begin
        state_nxt = state;
        case (state)
            act_gbf_pkg::EMPTY: begin
                if (rd_grant) begin
                    state_nxt = act_gbf_pkg::WAIT_DATA;
                end
            end
            // memory answers one cycle after the grant
            act_gbf_pkg::WAIT_DATA: begin
                state_nxt = act_gbf_pkg::HOLD;
            end
            act_gbf_pkg::HOLD: begin
                if (last_take) begin
                    state_nxt = act_gbf_pkg::EMPTY;
                end
            end
            default: begin
                state_nxt = act_gbf_pkg::EMPTY;
            end
        endcase
    end

    // ========================================================================
    // control registers
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= act_gbf_pkg::EMPTY;
            rd_req <= 1'b0;
            live_q <= '0;
        end else if (patch_reset) begin
            state  <= act_gbf_pkg::EMPTY;
            rd_req <= 1'b0;
            live_q <= '0;
        end else begin
            state <= state_nxt;
            // request is up for as long as the fetcher sits empty
            rd_req <= (state_nxt == act_gbf_pkg::EMPTY);
            if (state == act_gbf_pkg::WAIT_DATA) begin
                live_q <= '1;
            end else if (take) begin
                live_q <= live_q << item_w;
            end
        end
    end

    // held word, top item always at the msb end
    always_ff @(posedge clk) begin
        if (state == act_gbf_pkg::WAIT_DATA) begin
            word_q <= rdata;
        end else if (take) begin
            word_q <= word_q << item_w;
        end
    end

endmodule

/* design/act_dispatch.sv */
// activation dispatcher: rebuilds dense blocks from flags and drives the req/ack output
`timescale 1ns/100ps

module act_dispatch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    patch_reset,
    input  logic                    flag_valid,
    input  act_gbf_pkg::flag_t      flag,
    input  logic                    act_valid,
    input  act_gbf_pkg::act_t       act,
    input  logic                    blk_ack,
    output logic                    flag_take,
    output logic                    act_take,
    output logic                    blk_req,
    output act_gbf_pkg::act_block_t blk_act,
    output act_gbf_pkg::flag_t      blk_flag
);

    act_gbf_pkg::disp_state_e                    state;
    logic [$clog2(act_gbf_pkg::block_depth)-1:0] lane;
    logic                                        lane_set;
    logic                                        lane_done;
    logic                                        last_lane;

    // ========================================================================
    // lane walk
    // ========================================================================
    assign flag_take = (state == act_gbf_pkg::GET_FLAG) && flag_valid;
    assign lane_set  = blk_flag[lane];

    // set lane waits for an activation, clear lane just moves on
    assign act_take  = (state == act_gbf_pkg::GATHER) && lane_set && act_valid;
    assign lane_done = (state == act_gbf_pkg::GATHER) && (!lane_set || act_valid);
    assign last_lane = (lane == act_gbf_pkg::block_depth - 1);

    assign blk_req = (state == act_gbf_pkg::REQ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= act_gbf_pkg::GET_FLAG;
            lane  <= '0;
        end else if (patch_reset) begin
            state <= act_gbf_pkg::GET_FLAG;
            lane  <= '0;
        end else begin
            case (state)
                act_gbf_pkg::GET_FLAG: begin
                    if (flag_valid) begin
                        state <= act_gbf_pkg::GATHER;
                        lane  <= '0;
                    end
                end
                act_gbf_pkg::GATHER: begin
                    if (lane_done) begin
                        lane <= lane + 1'b1;
                        if (last_lane) begin
                            state <= act_gbf_pkg::REQ;
                        end
                    end
                end
                // four-phase: hold req until ack, then wait for ack to drop
                act_gbf_pkg::REQ: begin
                    if (blk_ack) begin
                        state <= act_gbf_pkg::RELEASE;
                    end
                end
                act_gbf_pkg::RELEASE: begin
                    if (!blk_ack) begin
                        state <= act_gbf_pkg::GET_FLAG;
                    end
                end
                default: begin
                    state <= act_gbf_pkg::GET_FLAG;
                end
            endcase
        end
    end

    // ========================================================================
    // block payload
    // ========================================================================

    // clear lanes stay zero from the flag take onwards
    always_ff @(posedge clk) begin
        if (flag_take) begin
            blk_flag <= flag;
            blk_act  <= '0;
        end else if (act_take) begin
            blk_act[lane*act_gbf_pkg::act_w +: act_gbf_pkg::act_w] <= act;
        end
    end

    // checks on the output handshake
    assert property (@(posedge clk) disable iff (!rst_n)
        blk_req && !blk_ack |=> $stable(blk_act) && $stable(blk_flag))
        else $error("block data changed before ack");

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(blk_req) |-> !blk_ack)
        else $error("blk_req rose while blk_ack still high");

endmodule

/* design/act_gbf_top.sv */
// activation global buffer top: shared memory, arbiter, two stream fetchers, dispatcher
`timescale 1ns/100ps

module act_gbf_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    patch_reset,
    input  logic                    wr_en,
    input  act_gbf_pkg::gbf_addr_t  wr_addr,
    input  act_gbf_pkg::port_word_t wr_data,
    input  logic                    blk_ack,
    output logic                    blk_req,
    output act_gbf_pkg::act_block_t blk_act,
    output act_gbf_pkg::flag_t      blk_flag
);

    // memory port
    logic                    mem_en;
    logic                    mem_we;
    act_gbf_pkg::gbf_addr_t  mem_addr;
    act_gbf_pkg::port_word_t mem_wdata;
    act_gbf_pkg::port_word_t mem_rdata;

    // fetch requests
    logic                    act_rd_req;
    logic                    act_rd_grant;
    logic                    flag_rd_req;
    logic                    flag_rd_grant;

    // unpacked items
    logic                    act_valid;
    logic                    act_take;
    act_gbf_pkg::act_t       act_item;
    logic                    flag_valid;
    logic                    flag_take;
    act_gbf_pkg::flag_t      flag_item;

    // ========================================================================
    // buffer and arbitration
    // ========================================================================
    gbf_sram gbf_sram_i (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    gbf_arbiter gbf_arbiter_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .patch_reset   (patch_reset),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .act_rd_req    (act_rd_req),
        .flag_rd_req   (flag_rd_req),
        .act_rd_grant  (act_rd_grant),
        .flag_rd_grant (flag_rd_grant),
        .mem_en        (mem_en),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata)
    );

    // ========================================================================
    // fetchers and dispatcher
    // ========================================================================
    stream_fetch #(
        .item_w (act_gbf_pkg::act_w)
    ) act_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .patch_reset (patch_reset),
        .rd_grant    (act_rd_grant),
        .rdata       (mem_rdata),
        .item_take   (act_take),
        .rd_req      (act_rd_req),
        .item_valid  (act_valid),
        .item        (act_item)
    );

    stream_fetch #(
        .item_w (act_gbf_pkg::block_depth)
    ) flag_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .patch_reset (patch_reset),
        .rd_grant    (flag_rd_grant),
        .rdata       (mem_rdata),
        .item_take   (flag_take),
        .rd_req      (flag_rd_req),
        .item_valid  (flag_valid),
        .item        (flag_item)
    );

    act_dispatch act_dispatch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .patch_reset (patch_reset),
        .flag_valid  (flag_valid),
        .flag        (flag_item),
        .act_valid   (act_valid),
        .act         (act_item),
        .blk_ack     (blk_ack),
        .flag_take   (flag_take),
        .act_take    (act_take),
        .blk_req     (blk_req),
        .blk_act     (blk_act),
        .blk_flag    (blk_flag)
    );

endmodule

/* sim/act_gbf_tb.sv */
// activation buffer testbench: region writer, four-phase acknowledger, block reference check
`timescale 1ns/100ps

module act_gbf_tb;

    localparam int timeout_cycles = 4000;
    localparam int random_blocks  = 200;

    logic                    clk;
    logic                    rst_n;
    logic                    patch_reset;
    logic                    wr_en;
    act_gbf_pkg::gbf_addr_t  wr_addr;
    act_gbf_pkg::port_word_t wr_data;
    logic                    blk_ack;
    logic                    blk_req;
    act_gbf_pkg::act_block_t blk_act;
    act_gbf_pkg::flag_t      blk_flag;

    integer seed = 32'h0aa3_f4ed;

    // words still to be written, and items already written
    logic [31:0]         flag_words [$];
    logic [31:0]         act_words [$];
    act_gbf_pkg::flag_t  flag_q [$];
    act_gbf_pkg::act_t   act_q [$];

    // word and item counts since the last reset
    int flag_wr_cnt  = 0;
    int act_wr_cnt   = 0;
    int flags_used   = 0;
    int acts_used    = 0;
    int blocks_seen  = 0;
    int blocks_target = 0;
    int ack_max      = 0;
    int failures     = 0;

    act_gbf_top act_gbf_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .patch_reset (patch_reset),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .blk_ack     (blk_ack),
        .blk_req     (blk_req),
        .blk_act     (blk_act),
        .blk_flag    (blk_flag)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ========================================================================
    // failure reporting and reference model
    // ========================================================================
    task automatic stop_run();
        failures = failures + 1;
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    // set lanes take the next activations in lane order, clear lanes read zero
    function automatic act_gbf_pkg::act_block_t expected_block(
        input act_gbf_pkg::flag_t f, ref act_gbf_pkg::act_t acts[$]);
        act_gbf_pkg::act_block_t blk;
        blk = '0;
        for (int lane = 0; lane < act_gbf_pkg::block_depth; lane++) begin
            if (f[lane]) begin
                blk[lane*act_gbf_pkg::act_w +: act_gbf_pkg::act_w] = acts.pop_front();
            end
        end
        return blk;
    endfunction

    // words granted so far are at least the words touched by used items
    function automatic bit flag_room();
        int touched;
        touched = (flags_used + act_gbf_pkg::flags_per_word - 1) / act_gbf_pkg::flags_per_word;
        return (flag_wr_cnt - touched) < act_gbf_pkg::region_words;
    endfunction

    function automatic bit act_room();
        int touched;
        touched = (acts_used + act_gbf_pkg::acts_per_word - 1) / act_gbf_pkg::acts_per_word;
        return (act_wr_cnt - touched) < act_gbf_pkg::region_words;
    endfunction

    // ========================================================================
    // writer
    // ========================================================================

    // items are unpacked left-first, msb end of the word first
    task automatic record_flag_word(input logic [31:0] w);
        for (int k = 0; k < act_gbf_pkg::flags_per_word; k++) begin
            flag_q.push_back(w[31-k*act_gbf_pkg::block_depth -: act_gbf_pkg::block_depth]);
        end
    endtask

    task automatic record_act_word(input logic [31:0] w);
        for (int k = 0; k < act_gbf_pkg::acts_per_word; k++) begin
            act_q.push_back(w[31-k*act_gbf_pkg::act_w -: act_gbf_pkg::act_w]);
        end
    endtask

    // enough activation words to cover the flags, counting leftovers
    task automatic plan_acts(input int needed);
        int words;
        logic [31:0] w;
        words = 0;
        if (needed > act_q.size()) begin
            words = (needed - act_q.size() + 3) / 4;
        end
        repeat (words) begin
            w = $random(seed);
            act_words.push_back(w);
        end
    endtask

    task automatic queue_random_flags(input int n_words);
        int pop;
        logic [31:0] w;
        pop = 0;
        repeat (n_words) begin
            w = $random(seed);
            flag_words.push_back(w);
            pop = pop + $countones(w);
        end
        plan_acts(pop);
    endtask

    task automatic write_words(input int gap_max);
        int gap;
        int stall;
        bit flag_turn;
        bit flag_ok;
        bit act_ok;
        logic [31:0] w;
        gap = 0;
        stall = 0;
        flag_turn = 1'b1;
        while (flag_words.size() > 0 || act_words.size() > 0) begin
            @(posedge clk);
            flag_ok = (flag_words.size() > 0) && flag_room();
            act_ok  = (act_words.size() > 0) && act_room();
            if (gap > 0) begin
                wr_en <= 1'b0;
                gap = gap - 1;
            end else if (flag_ok && (flag_turn || !act_ok)) begin
                w = flag_words.pop_front();
                wr_en   <= 1'b1;
                wr_addr <= act_gbf_pkg::gbf_addr_t'(act_gbf_pkg::region_words
                           + flag_wr_cnt % act_gbf_pkg::region_words);
                wr_data <= w;
                record_flag_word(w);
                flag_wr_cnt = flag_wr_cnt + 1;
                flag_turn = 1'b0;
                stall = 0;
                gap = $unsigned($random(seed)) % (gap_max + 1);
            end else if (act_ok) begin
                w = act_words.pop_front();
                wr_en   <= 1'b1;
                wr_addr <= act_gbf_pkg::gbf_addr_t'(act_wr_cnt % act_gbf_pkg::region_words);
                wr_data <= w;
                record_act_word(w);
                act_wr_cnt = act_wr_cnt + 1;
                flag_turn = 1'b1;
                stall = 0;
                gap = $unsigned($random(seed)) % (gap_max + 1);
            end else begin
                wr_en <= 1'b0;
                stall = stall + 1;
                if (stall > timeout_cycles) begin
                    $display("writer found no free buffer space for too long");
                    stop_run();
                end
            end
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // ========================================================================
    // waits
    // ========================================================================
    task automatic wait_blocks(input int target);
        int idle;
        int last;
        idle = 0;
        last = blocks_seen;
        while (blocks_seen < target) begin
            @(negedge clk);
            if (blocks_seen != last) begin
                last = blocks_seen;
                idle = 0;
            end else begin
                idle = idle + 1;
                if (idle > timeout_cycles) begin
                    $display("timed out waiting for block %0d of %0d", blocks_seen + 1, target);
                    stop_run();
                end
            end
        end
    endtask

    task automatic wait_quiet();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (blk_req || blk_ack) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > timeout_cycles) begin
                $display("handshake did not return to idle");
                stop_run();
            end
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (blk_req) begin
                $display("blk_req rose with no complete block available");
                stop_run();
            end
        end
    endtask

    task automatic run_batch(input int gap_max, input int n_blocks);
        blocks_target = blocks_target + n_blocks;
        write_words(gap_max);
        wait_blocks(blocks_target);
    endtask

    // ========================================================================
    // acknowledger and compare
    // ========================================================================
    initial begin : ack_proc
        int ack_wait;
        blk_ack <= 1'b0;
        ack_wait = 0;
        forever begin
            @(negedge clk);
            if (blk_ack && !blk_req) begin
                @(posedge clk);
                blk_ack <= 1'b0;
            end else if (!blk_ack && blk_req) begin
                if (ack_wait == 0) begin
                    @(posedge clk);
                    blk_ack <= 1'b1;
                    ack_wait = $unsigned($random(seed)) % (ack_max + 1);
                end else begin
                    ack_wait = ack_wait - 1;
                end
            end
        end
    end

    initial begin : compare_proc
        logic                    req_prev;
        act_gbf_pkg::flag_t      exp_flag;
        act_gbf_pkg::act_block_t exp_act;
        req_prev = 1'b0;
        forever begin
            @(negedge clk);
            if (blk_req && !req_prev) begin
                if (blk_ack) begin
                    $display("blk_req rose while blk_ack was still high");
                    stop_run();
                end else if (flag_q.size() == 0) begin
                    $display("block offered with no flag item written");
                    stop_run();
                end else if ($countones(flag_q[0]) > act_q.size()) begin
                    $display("block offered before its activations were written");
                    stop_run();
                end else begin
                    exp_flag = flag_q.pop_front();
                    exp_act  = expected_block(exp_flag, act_q);
                    check_value("blk_flag", blk_flag, exp_flag);
                    check_value("blk_act", blk_act, exp_act);
                    blocks_seen = blocks_seen + 1;
                    flags_used  = flags_used + 1;
                    acts_used   = acts_used + $countones(exp_flag);
                end
            end
            req_prev = blk_req;
        end
    end

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin : main_proc
        rst_n       <= 1'b0;
        patch_reset <= 1'b0;
        wr_en       <= 1'b0;
        wr_addr     <= '0;
        wr_data     <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // empty buffer, nothing may come out
        check_idle(timeout_cycles);

        // one flag word with exactly four activation words
        ack_max = 2;
        flag_words.push_back(32'h3c5a_f096);
        plan_acts(16);
        run_batch(0, 8);

        // random flags and activations, slow acks
        ack_max = 7;
        queue_random_flags(random_blocks / act_gbf_pkg::flags_per_word);
        run_batch(3, random_blocks);

        // zero lanes and full lanes
        ack_max = 1;
        flag_words.push_back(32'h0f0f_f00f);
        plan_acts(16);
        run_batch(1, 8);

        // back-to-back writes against fast consumption
        ack_max = 0;
        queue_random_flags(12);
        run_batch(0, 96);

        // one block goes out, the second starves, then the patch is dropped
        ack_max = 3;
        flag_words.push_back(32'hffff_ffff);
        flag_words.push_back(32'hffff_ffff);
        act_words.push_back($random(seed));
        run_batch(1, 1);
        wait_quiet();
        check_idle(20);
        @(posedge clk);
        patch_reset <= 1'b1;
        flag_q.delete();
        act_q.delete();
        flag_wr_cnt = 0;
        act_wr_cnt  = 0;
        flags_used  = 0;
        acts_used   = 0;
        @(posedge clk);
        patch_reset <= 1'b0;

        // fresh stream from offset 0 of both regions
        queue_random_flags(5);
        run_batch(2, 40);
        wait_quiet();
        check_idle(50);

        if (failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* act_gbf_top.f */
design/act_gbf_pkg.sv
design/gbf_sram.sv
design/gbf_arbiter.sv
design/stream_fetch.sv
design/act_dispatch.sv
design/act_gbf_top.sv
sim/act_gbf_tb.sv
